// ==== logic/frame_pkg.sv ====
// Shared definitions for the clock and reset frame
// APB register map, width typedefs and the watchdog state enum

package frame_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [7:0]  loss_cnt_t;
    typedef logic [7:0]  hold_cnt_t;

    ////////////////////////////////////////////////////////////
    // Register map
    // Control, bit 0 requests a soft reset
    localparam apb_addr_t ADDR_CTRL   = 8'h00;
    // Status, read only
    localparam apb_addr_t ADDR_STATUS = 8'h04;
    // Lock loss count, any write clears it
    localparam apb_addr_t ADDR_LOSS   = 8'h08;

    // First per-domain ready bit in the status word
    localparam int STATUS_READY_LSB = 8;

    // PLL watchdog states
    typedef enum logic {
        WD_IDLE,
        WD_HOLD
    } wd_state_t;

endpackage

// ==== logic/pll_watchdog.sv ====
// PLL lock watchdog
// Detects a falling lock and holds the PLL in reset for a fixed time

`timescale 1ns/1ns

module pll_watchdog
    import frame_pkg::*;
#(
    parameter int PLL_HOLD = 255
) (
    input  logic clk_sys,
    input  logic RESET,
    input  logic pll_locked,
    output logic pll_rst,
    output logic lock_lost
);

    wd_state_t state;
    hold_cnt_t hold_cnt;
    logic      lock_q;
    logic      lock_d;
    logic      lock_fall;

    // Lock comes straight from the PLL, sample it before use
    assign lock_fall = lock_d & ~lock_q;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            lock_q    <= 1'b0;
            lock_d    <= 1'b0;
            state     <= WD_IDLE;
            hold_cnt  <= '0;
            lock_lost <= 1'b0;
        end else begin
            lock_q    <= pll_locked;
            lock_d    <= lock_q;
            lock_lost <= lock_fall;
            if (lock_fall) begin
                // Also restarts a hold already in progress
                state    <= WD_HOLD;
                hold_cnt <= hold_cnt_t'(PLL_HOLD);
            end else if (state == WD_HOLD) begin
                if (hold_cnt == '0) begin
                    state <= WD_IDLE;
                end else begin
                    hold_cnt <= hold_cnt - 1'b1;
                end
            end
        end
    end

    assign pll_rst = (state == WD_HOLD);

endmodule

// ==== logic/game_reset_gen.sv ====
// Game reset generator
// Merges external, soft, button and PLL resets and stretches the release

`timescale 1ns/1ns

module game_reset_gen
    import frame_pkg::*;
#(
    parameter int GAME_HOLD = 16
) (
    input  logic clk_sys,
    input  logic RESET,
    input  logic pll_locked,
    input  logic pll_rst,
    input  logic soft_rst,
    input  logic button_rst,
    output logic game_rst
);

    hold_cnt_t stretch_cnt;
    logic      rst_src;
    logic      rst_q;

    ////////////////////////////////////////////////////////////
    // Reset sources

    // Unlocked PLL counts as a reset request on its own
    assign rst_src = soft_rst | button_rst | pll_rst | ~pll_locked;

    ////////////////////////////////////////////////////////////
    // Stretch counter

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            stretch_cnt <= hold_cnt_t'(GAME_HOLD);
            rst_q       <= 1'b1;
        end else begin
            if (rst_src) begin
                stretch_cnt <= hold_cnt_t'(GAME_HOLD);
                rst_q       <= 1'b1;
            end else begin
                // Release once the count has run out
                rst_q <= (stretch_cnt != '0);
                if (stretch_cnt != '0) begin
                    stretch_cnt <= stretch_cnt - 1'b1;
                end
            end
        end
    end

    assign game_rst = rst_q;

endmodule

// ==== logic/domain_rst_sync.sv ====
// Reset synchronizer for one generated clock domain
// Asserts at once, releases on the second edge of the domain clock

`timescale 1ns/1ns

module domain_rst_sync (
    input  logic clk_dom,
    input  logic game_rst,
    output logic rst_dom
);

    logic [1:0] sync_q;

    // Set straight from game_rst, drained by the local clock
    always_ff @(posedge clk_dom or posedge game_rst) begin
        if (game_rst) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], 1'b0};
        end
    end

    assign rst_dom = sync_q[1];

endmodule

// ==== logic/domain_ready_sync.sv ====
// Domain ready collector
// Brings each domain's reset release back into clk_sys

`timescale 1ns/1ns

module domain_ready_sync #(
    parameter int NUM_DOMAINS = 4
) (
    input  logic                   clk_sys,
    input  logic                   RESET,
    input  logic [NUM_DOMAINS-1:0] rst_dom,
    output logic [NUM_DOMAINS-1:0] domains_ready
);

    logic [NUM_DOMAINS-1:0] ready_meta;
    logic [NUM_DOMAINS-1:0] ready_q;

    // Two flops per domain, first one may go metastable
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            ready_meta <= '0;
            ready_q    <= '0;
        end else begin
            ready_meta <= ~rst_dom;
            ready_q    <= ready_meta;
        end
    end

    assign domains_ready = ready_q;

endmodule

// ==== logic/host_regs.sv ====
// Host register block on APB
// Control with soft reset, read-only status and the lock loss counter

`timescale 1ns/1ns

module host_regs
    import frame_pkg::*;
#(
    parameter int NUM_DOMAINS = 4
) (
    input  logic                   clk_sys,
    input  logic                   RESET,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_addr_t              paddr,
    input  apb_data_t              pwdata,
    input  logic                   pll_locked,
    input  logic                   game_rst,
    input  logic                   lock_lost,
    input  logic [NUM_DOMAINS-1:0] domains_ready,
    output apb_data_t              prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   soft_rst
);

    loss_cnt_t loss_cnt;
    apb_data_t status_word;
    logic      access;
    logic      addr_hit;
    logic      wr_ctrl;
    logic      wr_loss;

    ////////////////////////////////////////////////////////////
    // Decode

    // Zero wait states, every access phase completes
    assign access   = psel & penable;
    assign addr_hit = (paddr == ADDR_CTRL) || (paddr == ADDR_STATUS) || (paddr == ADDR_LOSS);
    assign wr_ctrl  = access & pwrite & (paddr == ADDR_CTRL);
    assign wr_loss  = access & pwrite & (paddr == ADDR_LOSS);

    assign pready  = 1'b1;
    assign pslverr = access & ~addr_hit;

    ////////////////////////////////////////////////////////////
    // Registers

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            soft_rst <= 1'b0;
            loss_cnt <= '0;
        end else begin
            if (wr_ctrl) begin
                soft_rst <= pwdata[0];
            end
            // Clear wins, but a pulse in the same cycle still counts
            if (wr_loss) begin
                loss_cnt <= lock_lost ? loss_cnt_t'(1) : '0;
            end else if (lock_lost && !(&loss_cnt)) begin
                loss_cnt <= loss_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read path

    always_comb begin
        status_word    = '0;
        status_word[0] = pll_locked;
        status_word[1] = game_rst;
        status_word[STATUS_READY_LSB +: NUM_DOMAINS] = domains_ready;
    end

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                ADDR_CTRL:   prdata[0] = soft_rst;
                ADDR_STATUS: prdata = status_word;
                ADDR_LOSS:   prdata[$bits(loss_cnt_t)-1:0] = loss_cnt;
                default:     prdata = '0;
            endcase
        end
    end

endmodule

// ==== logic/frame_clkrst.sv ====
// Clock and reset frame, top level
// PLL watchdog, game reset generator, per-domain reset synchronizers,
// ready collector and the APB host registers

`timescale 1ns/1ns

module frame_clkrst
    import frame_pkg::*;
#(
    parameter int NUM_DOMAINS = 4,
    parameter int PLL_HOLD    = 255,
    parameter int GAME_HOLD   = 16
) (
    input  logic                   clk_sys,
    input  logic                   RESET,
    input  logic                   pll_locked,
    input  logic                   button_rst,
    input  logic [NUM_DOMAINS-1:0] clk_dom,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  apb_addr_t              paddr,
    input  apb_data_t              pwdata,
    output apb_data_t              prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   pll_rst,
    output logic                   game_rst,
    output logic [NUM_DOMAINS-1:0] rst_dom
);

    logic                   lock_lost;
    logic                   soft_rst;
    logic [NUM_DOMAINS-1:0] domains_ready;

    ////////////////////////////////////////////////////////////
    // clk_sys resets

    pll_watchdog #(
        .PLL_HOLD   ( PLL_HOLD   )
    ) u_watchdog (
        .clk_sys    ( clk_sys    ),
        .RESET      ( RESET      ),
        .pll_locked ( pll_locked ),
        .pll_rst    ( pll_rst    ),
        .lock_lost  ( lock_lost  )
    );

    game_reset_gen #(
        .GAME_HOLD  ( GAME_HOLD  )
    ) u_game_rst (
        .clk_sys    ( clk_sys    ),
        .RESET      ( RESET      ),
        .pll_locked ( pll_locked ),
        .pll_rst    ( pll_rst    ),
        .soft_rst   ( soft_rst   ),
        .button_rst ( button_rst ),
        .game_rst   ( game_rst   )
    );

    ////////////////////////////////////////////////////////////
    // One synchronizer per generated clock

    for (genvar i = 0; i < NUM_DOMAINS; i++) begin : u_sync
        domain_rst_sync u_rst (
            .clk_dom  ( clk_dom[i] ),
            .game_rst ( game_rst   ),
            .rst_dom  ( rst_dom[i] )
        );
    end

    domain_ready_sync #(
        .NUM_DOMAINS   ( NUM_DOMAINS   )
    ) u_ready (
        .clk_sys       ( clk_sys       ),
        .RESET         ( RESET         ),
        .rst_dom       ( rst_dom       ),
        .domains_ready ( domains_ready )
    );

    ////////////////////////////////////////////////////////////
    // Host access

    host_regs #(
        .NUM_DOMAINS   ( NUM_DOMAINS   )
    ) u_regs (
        .clk_sys       ( clk_sys       ),
        .RESET         ( RESET         ),
        .psel          ( psel          ),
        .penable       ( penable       ),
        .pwrite        ( pwrite        ),
        .paddr         ( paddr         ),
        .pwdata        ( pwdata        ),
        .pll_locked    ( pll_locked    ),
        .game_rst      ( game_rst      ),
        .lock_lost     ( lock_lost     ),
        .domains_ready ( domains_ready ),
        .prdata        ( prdata        ),
        .pready        ( pready        ),
        .pslverr       ( pslverr       ),
        .soft_rst      ( soft_rst      )
    );

endmodule

// ==== test/tb_frame_clkrst.sv ====
// Testbench for the clock and reset frame
// Clocks, APB access tasks, reset timing and register checks

`timescale 1ns/1ns

module tb_frame_clkrst
    import frame_pkg::*;
();

    localparam int NUM_DOMAINS = 4;
    localparam int PLL_HOLD    = 255;
    localparam int GAME_HOLD   = 16;
    localparam logic [NUM_DOMAINS-1:0] ALL_DOMAINS = '1;

    logic                   clk_sys;
    logic                   RESET;
    logic                   pll_locked;
    logic                   button_rst;
    logic [NUM_DOMAINS-1:0] clk_dom;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    apb_addr_t              paddr;
    apb_data_t              pwdata;
    apb_data_t              prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   pll_rst;
    logic                   game_rst;
    logic [NUM_DOMAINS-1:0] rst_dom;

    logic [31:0] rng_state;
    apb_data_t   rd_data;
    apb_data_t   loss_before;
    logic        rd_err;
    int          pll_high;

    frame_clkrst #(
        .NUM_DOMAINS ( NUM_DOMAINS ),
        .PLL_HOLD    ( PLL_HOLD    ),
        .GAME_HOLD   ( GAME_HOLD   )
    ) u_dut (.*);

    ////////////////////////////////////////////////////////////
    // Clocks for the 8 ns system and four unrelated domains
    always #4 clk_sys = ~clk_sys;
    always #3 clk_dom[0] = ~clk_dom[0];
    always #5 clk_dom[1] = ~clk_dom[1];
    always #6 clk_dom[2] = ~clk_dom[2];
    always #10 clk_dom[3] = ~clk_dom[3];

    ////////////////////////////////////////////////////////////
    // Helpers
    task automatic fail_now(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input apb_data_t exp, input apb_data_t act);
        assert (exp == act)
            else fail_now($sformatf("mismatch %s expected %0h actual %0h", name, exp, act));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Status layout with lock in bit 0, game reset in bit 1 and ready bits from bit 8
    function automatic apb_data_t expected_status(input logic locked, input logic grst,
                                                  input logic [NUM_DOMAINS-1:0] ready);
        apb_data_t word;
        word = '0;
        word[0] = locked;
        word[1] = grst;
        word[STATUS_READY_LSB +: NUM_DOMAINS] = ready;
        return word;
    endfunction

    // Setup phase, access phase and idle on falling edges
    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t data,
                              output apb_data_t rdata, output logic err);
        @(negedge clk_sys);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk_sys);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err   = pslverr;
        assert (pready) else fail_now("pready was low in an APB access phase");
        @(negedge clk_sys);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        if (err) fail_now($sformatf("pslverr on a read of mapped address %0h", addr));
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        apb_data_t unused;
        logic      err;
        apb_access(1'b1, addr, data, unused, err);
        if (err) fail_now($sformatf("pslverr on a write to mapped address %0h", addr));
    endtask

    // Called on the falling edge where the last reset source clears
    task automatic count_game_rst_hold(input string name);
        int n;
        n = 0;
        for (int i = 0; i < 100 && game_rst; i++) begin
            @(negedge clk_sys);
            if (game_rst) n++;
        end
        if (game_rst) fail_now("game_rst did not release in time");
        check_value(name, GAME_HOLD, n);
    endtask

    task automatic wait_domains_ready(input string name);
        for (int i = 0; i < 50 && rst_dom != '0; i++) begin
            @(negedge clk_sys);
        end
        if (rst_dom != '0) fail_now("domain resets did not release in time");
        // Two clk_sys edges through the ready collector
        repeat (2) @(negedge clk_sys);
        apb_read(ADDR_STATUS, rd_data);
        check_value(name, expected_status(1'b1, 1'b0, ALL_DOMAINS), rd_data);
    endtask

    ////////////////////////////////////////////////////////////
    // Protocol and reset invariants
    assert property (@(posedge clk_sys) (psel && penable) |-> pready)
        else fail_now("pready was low in an APB access phase");
    assert property (@(posedge clk_sys) !(psel && penable) |-> !pslverr)
        else fail_now("pslverr was high outside an APB access");
    assert property (@(posedge clk_sys) game_rst |-> (&rst_dom))
        else fail_now("a domain reset was low while game_rst was high");

    ////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        rng_state  = 32'h2f34;
        clk_sys    = 1'b0;
        clk_dom    = '0;
        RESET      = 1'b1;
        pll_locked = 1'b0;
        button_rst = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        repeat (5) @(negedge clk_sys);
        RESET = 1'b0;
        @(negedge clk_sys);

        // Bring-up
        check_value("reset pll_rst", 0, pll_rst);
        check_value("reset game_rst", 1, game_rst);
        check_value("reset rst_dom", ALL_DOMAINS, rst_dom);
        apb_read(ADDR_LOSS, rd_data);
        check_value("reset loss count", 0, rd_data);
        pll_locked = 1'b1;
        count_game_rst_hold("bring-up hold");
        wait_domains_ready("bring-up status");

        // Loss of lock for four cycles
        apb_read(ADDR_LOSS, loss_before);
        check_value("loss count before", 0, loss_before);
        pll_locked = 1'b0;
        @(negedge clk_sys);
        check_value("loss game_rst", 1, game_rst);
        check_value("loss pll_rst delay", 0, pll_rst);
        @(negedge clk_sys);
        check_value("loss pll_rst rise", 1, pll_rst);
        pll_high = 1;
        for (int i = 0; i < 400 && pll_rst; i++) begin
            if (i == 2) pll_locked = 1'b1;
            @(negedge clk_sys);
            if (pll_rst) pll_high++;
        end
        if (pll_rst) fail_now("pll_rst stayed high past its hold time");
        check_value("pll_rst hold", PLL_HOLD + 1, pll_high);
        count_game_rst_hold("loss hold");
        apb_read(ADDR_LOSS, rd_data);
        check_value("loss count", 1, rd_data);
        rng_state = xorshift32(rng_state);
        apb_write(ADDR_LOSS, rng_state);
        apb_read(ADDR_LOSS, rd_data);
        check_value("loss clear", 0, rd_data);
        wait_domains_ready("loss status");

        // Soft reset
        apb_write(ADDR_CTRL, 32'h1);
        check_value("soft game_rst delay", 0, game_rst);
        @(negedge clk_sys);
        check_value("soft game_rst", 1, game_rst);
        check_value("soft rst_dom", ALL_DOMAINS, rst_dom);
        apb_read(ADDR_STATUS, rd_data);
        check_value("soft status", expected_status(1'b1, 1'b1, '0), rd_data);
        apb_write(ADDR_CTRL, 32'h0);
        count_game_rst_hold("soft hold");
        wait_domains_ready("soft status after release");

        // Button reset
        button_rst = 1'b1;
        @(negedge clk_sys);
        check_value("button game_rst", 1, game_rst);
        check_value("button rst_dom", ALL_DOMAINS, rst_dom);
        apb_read(ADDR_STATUS, rd_data);
        check_value("button status", expected_status(1'b1, 1'b1, '0), rd_data);
        button_rst = 1'b0;
        count_game_rst_hold("button hold");
        wait_domains_ready("button status after release");

        // Register rules
        for (int i = 0; i < 8; i++) begin
            rng_state = xorshift32(rng_state);
            apb_write(ADDR_CTRL, rng_state);
            apb_read(ADDR_CTRL, rd_data);
            check_value("ctrl readback", {31'b0, rng_state[0]}, rd_data);
        end
        apb_write(ADDR_CTRL, 32'h0);
        apb_access(1'b0, 8'h0c, '0, rd_data, rd_err);
        check_value("unmapped read data", 0, rd_data);
        check_value("unmapped read pslverr", 1, rd_err);
        apb_access(1'b1, 8'h40, rng_state, rd_data, rd_err);
        check_value("unmapped write pslverr", 1, rd_err);

        $display("test passed");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/frame_pkg.sv
logic/pll_watchdog.sv
logic/game_reset_gen.sv
logic/domain_rst_sync.sv
logic/domain_ready_sync.sv
logic/host_regs.sv
logic/frame_clkrst.sv
test/tb_frame_clkrst.sv
